// File: hdl/llc_msg_pkg.sv
`default_nettype none

package llc_msg_pkg;

    // Field widths
    localparam int unsigned COH_MSG_W  = 3;
    localparam int unsigned ADDR_W     = 16;
    localparam int unsigned LINE_W     = 64;
    localparam int unsigned REQ_ID_W   = 2;
    localparam int unsigned HPROT_W    = 2;
    localparam int unsigned WORD_OFF_W = 1;

    // CPU and DMA requests share one layout
    typedef struct packed {
        logic [COH_MSG_W-1:0]  coh_msg;
        logic [HPROT_W-1:0]    hprot;
        logic [ADDR_W-1:0]     addr;
        logic [LINE_W-1:0]     line;
        logic [REQ_ID_W-1:0]   req_id;
        logic [WORD_OFF_W-1:0] word_offset;
        logic [WORD_OFF_W-1:0] valid_words;
    } llc_req_t;

    // Coherence response from another cache
    typedef struct packed {
        logic [COH_MSG_W-1:0] coh_msg;
        logic [ADDR_W-1:0]    addr;
        logic [LINE_W-1:0]    line;
        logic [REQ_ID_W-1:0]  req_id;
    } llc_rsp_t;

    typedef struct packed {
        logic [LINE_W-1:0] line;
    } llc_mem_rsp_t;

    typedef struct packed {
        logic flush;
    } llc_flush_t;

endpackage

`default_nettype wire

// File: hdl/llc_chan_pkg.sv
`default_nettype none

package llc_chan_pkg;

    localparam int unsigned NUM_CHAN    = 5;
    localparam int unsigned CHAN_MASK_W = NUM_CHAN;

    typedef enum logic [2:0] {
        CH_NONE    = 3'd0,
        CH_FLUSH   = 3'd1,
        CH_MEM_RSP = 3'd2,
        CH_RSP     = 3'd3,
        CH_REQ     = 3'd4,
        CH_DMA     = 3'd5
    } chan_id_t;

    // Enable mask bit positions
    localparam int unsigned MASK_FLUSH   = 0;
    localparam int unsigned MASK_MEM_RSP = 1;
    localparam int unsigned MASK_RSP     = 2;
    localparam int unsigned MASK_REQ     = 3;
    localparam int unsigned MASK_DMA     = 4;

    // Config register map
    localparam logic CFG_ADDR_MASK = 1'b0;
    localparam logic CFG_ADDR_PRIO = 1'b1;

    localparam logic [CHAN_MASK_W-1:0] CFG_MASK_RST = '1;
    localparam logic                   CFG_PRIO_RST = 1'b0;

endpackage

`default_nettype wire

// File: hdl/llc_bypass_slot.sv
`timescale 1ns/1ps
`default_nettype none

module llc_bypass_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     grant_i
);

    logic     ready_q;
    logic     held_q;
    payload_t held_data_q;
    logic     xfer_in;

    assign xfer_in = valid_i && ready_q;

    // Ready falls only while a message is parked
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready_q <= 1'b1;
            held_q  <= 1'b0;
        end else if (grant_i) begin
            // Core took whatever was offered
            ready_q <= 1'b1;
            held_q  <= 1'b0;
        end else if (xfer_in) begin
            ready_q <= 1'b0;
            held_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_in && !grant_i) begin
            held_data_q <= data_i;
        end
    end

    // Held message wins over the live input
    assign data_o  = held_q ? held_data_q : data_i;
    assign valid_o = held_q | valid_i;
    assign ready_o = ready_q;

endmodule

`default_nettype wire

// File: hdl/llc_input_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module llc_input_cfg
    import llc_chan_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cfg_we_i,
    input  logic                   cfg_addr_i,
    input  logic [CHAN_MASK_W-1:0] cfg_wdata_i,
    output logic [CHAN_MASK_W-1:0] cfg_rdata_o,
    output logic [CHAN_MASK_W-1:0] chan_en_o,
    output logic                   dma_first_o
);

    logic [CHAN_MASK_W-1:0] chan_en_q;
    logic                   dma_first_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            chan_en_q   <= CFG_MASK_RST;
            dma_first_q <= CFG_PRIO_RST;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == CFG_ADDR_MASK) begin
                chan_en_q <= cfg_wdata_i;
            end else begin
                // Only bit 0 is stored for the priority register
                dma_first_q <= cfg_wdata_i[0];
            end
        end
    end

    // Readback of the addressed register
    always_comb begin
        if (cfg_addr_i == CFG_ADDR_PRIO) begin
            cfg_rdata_o = {{(CHAN_MASK_W-1){1'b0}}, dma_first_q};
        end else begin
            cfg_rdata_o = chan_en_q;
        end
    end

    assign chan_en_o   = chan_en_q;
    assign dma_first_o = dma_first_q;

endmodule

`default_nettype wire

// File: hdl/llc_channel_select.sv
`timescale 1ns/1ps
`default_nettype none

module llc_channel_select
    import llc_msg_pkg::*;
    import llc_chan_pkg::*;
(
    input  logic                   flush_valid_i,
    input  llc_flush_t             flush_data_i,
    input  logic                   mem_valid_i,
    input  llc_mem_rsp_t           mem_data_i,
    input  logic                   rsp_valid_i,
    input  llc_rsp_t               rsp_data_i,
    input  logic                   req_valid_i,
    input  llc_req_t               req_data_i,
    input  logic                   dma_valid_i,
    input  llc_req_t               dma_data_i,
    input  logic [CHAN_MASK_W-1:0] chan_en_i,
    input  logic                   dma_first_i,
    input  logic                   sel_ready_i,
    output logic                   flush_grant_o,
    output logic                   mem_grant_o,
    output logic                   rsp_grant_o,
    output logic                   req_grant_o,
    output logic                   dma_grant_o,
    output logic                   sel_valid_o,
    output chan_id_t               sel_chan_o,
    output logic [COH_MSG_W-1:0]   sel_coh_msg_o,
    output logic [HPROT_W-1:0]     sel_hprot_o,
    output logic [ADDR_W-1:0]      sel_addr_o,
    output logic [LINE_W-1:0]      sel_line_o,
    output logic [REQ_ID_W-1:0]    sel_req_id_o,
    output logic [WORD_OFF_W-1:0]  sel_word_offset_o,
    output logic [WORD_OFF_W-1:0]  sel_valid_words_o,
    output logic                   sel_flush_o
);

    logic     flush_act;
    logic     mem_act;
    logic     rsp_act;
    logic     req_act;
    logic     dma_act;
    chan_id_t pick;
    llc_req_t win_req;

    // Disabled channels stay parked in their slots
    assign flush_act = flush_valid_i && chan_en_i[MASK_FLUSH];
    assign mem_act   = mem_valid_i && chan_en_i[MASK_MEM_RSP];
    assign rsp_act   = rsp_valid_i && chan_en_i[MASK_RSP];
    assign req_act   = req_valid_i && chan_en_i[MASK_REQ];
    assign dma_act   = dma_valid_i && chan_en_i[MASK_DMA];

    always_comb begin
        pick = CH_NONE;
        if (flush_act) begin
            pick = CH_FLUSH;
        end else if (mem_act) begin
            pick = CH_MEM_RSP;
        end else if (rsp_act) begin
            pick = CH_RSP;
        end else if (dma_first_i && dma_act) begin
            pick = CH_DMA;
        end else if (req_act) begin
            pick = CH_REQ;
        end else if (dma_act) begin
            pick = CH_DMA;
        end
    end

    assign sel_valid_o = (pick != CH_NONE);
    assign sel_chan_o  = pick;

    assign flush_grant_o = sel_ready_i && (pick == CH_FLUSH);
    assign mem_grant_o   = sel_ready_i && (pick == CH_MEM_RSP);
    assign rsp_grant_o   = sel_ready_i && (pick == CH_RSP);
    assign req_grant_o   = sel_ready_i && (pick == CH_REQ);
    assign dma_grant_o   = sel_ready_i && (pick == CH_DMA);

    // Both request channels share one layout
    assign win_req = (pick == CH_DMA) ? dma_data_i : req_data_i;

    // Fields a channel does not carry read as zero
    always_comb begin
        sel_coh_msg_o     = '0;
        sel_hprot_o       = '0;
        sel_addr_o        = '0;
        sel_line_o        = '0;
        sel_req_id_o      = '0;
        sel_word_offset_o = '0;
        sel_valid_words_o = '0;
        sel_flush_o       = 1'b0;
        case (pick)
            CH_FLUSH: begin
                sel_flush_o = flush_data_i.flush;
            end
            CH_MEM_RSP: begin
                sel_line_o = mem_data_i.line;
            end
            CH_RSP: begin
                sel_coh_msg_o = rsp_data_i.coh_msg;
                sel_addr_o    = rsp_data_i.addr;
                sel_line_o    = rsp_data_i.line;
                sel_req_id_o  = rsp_data_i.req_id;
            end
            CH_REQ, CH_DMA: begin
                sel_coh_msg_o     = win_req.coh_msg;
                sel_hprot_o       = win_req.hprot;
                sel_addr_o        = win_req.addr;
                sel_line_o        = win_req.line;
                sel_req_id_o      = win_req.req_id;
                sel_word_offset_o = win_req.word_offset;
                sel_valid_words_o = win_req.valid_words;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/llc_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

module llc_input_stage
    import llc_msg_pkg::*;
    import llc_chan_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cfg_we_i,
    input  logic                   cfg_addr_i,
    input  logic [CHAN_MASK_W-1:0] cfg_wdata_i,
    output logic [CHAN_MASK_W-1:0] cfg_rdata_o,
    // Flush command
    input  logic                   flush_valid_i,
    output logic                   flush_ready_o,
    input  logic                   flush_flag_i,
    // Memory response
    input  logic                   mem_rsp_valid_i,
    output logic                   mem_rsp_ready_o,
    input  logic [LINE_W-1:0]      mem_rsp_line_i,
    // Coherence response
    input  logic                   rsp_valid_i,
    output logic                   rsp_ready_o,
    input  logic [COH_MSG_W-1:0]   rsp_coh_msg_i,
    input  logic [ADDR_W-1:0]      rsp_addr_i,
    input  logic [LINE_W-1:0]      rsp_line_i,
    input  logic [REQ_ID_W-1:0]    rsp_req_id_i,
    // CPU request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [COH_MSG_W-1:0]   req_coh_msg_i,
    input  logic [HPROT_W-1:0]     req_hprot_i,
    input  logic [ADDR_W-1:0]      req_addr_i,
    input  logic [LINE_W-1:0]      req_line_i,
    input  logic [REQ_ID_W-1:0]    req_req_id_i,
    input  logic [WORD_OFF_W-1:0]  req_word_offset_i,
    input  logic [WORD_OFF_W-1:0]  req_valid_words_i,
    // DMA request
    input  logic                   dma_valid_i,
    output logic                   dma_ready_o,
    input  logic [COH_MSG_W-1:0]   dma_coh_msg_i,
    input  logic [HPROT_W-1:0]     dma_hprot_i,
    input  logic [ADDR_W-1:0]      dma_addr_i,
    input  logic [LINE_W-1:0]      dma_line_i,
    input  logic [REQ_ID_W-1:0]    dma_req_id_i,
    input  logic [WORD_OFF_W-1:0]  dma_word_offset_i,
    input  logic [WORD_OFF_W-1:0]  dma_valid_words_i,
    // Toward the cache core
    input  logic                   sel_ready_i,
    output logic                   sel_valid_o,
    output chan_id_t               sel_chan_o,
    output logic [COH_MSG_W-1:0]   sel_coh_msg_o,
    output logic [HPROT_W-1:0]     sel_hprot_o,
    output logic [ADDR_W-1:0]      sel_addr_o,
    output logic [LINE_W-1:0]      sel_line_o,
    output logic [REQ_ID_W-1:0]    sel_req_id_o,
    output logic [WORD_OFF_W-1:0]  sel_word_offset_o,
    output logic [WORD_OFF_W-1:0]  sel_valid_words_o,
    output logic                   sel_flush_o
);

    llc_flush_t   flush_in, flush_out;
    llc_mem_rsp_t mem_in, mem_out;
    llc_rsp_t     rsp_in, rsp_out;
    llc_req_t     req_in, req_out;
    llc_req_t     dma_in, dma_out;

    logic flush_vld, mem_vld, rsp_vld, req_vld, dma_vld;
    logic flush_gnt, mem_gnt, rsp_gnt, req_gnt, dma_gnt;

    logic [CHAN_MASK_W-1:0] chan_en;
    logic                   dma_first;

    // Pack loose fields into channel payloads
    assign flush_in = '{flush: flush_flag_i};
    assign mem_in   = '{line: mem_rsp_line_i};
    assign rsp_in   = '{coh_msg: rsp_coh_msg_i, addr: rsp_addr_i,
                        line: rsp_line_i, req_id: rsp_req_id_i};
    assign req_in   = '{coh_msg: req_coh_msg_i, hprot: req_hprot_i, addr: req_addr_i,
                        line: req_line_i, req_id: req_req_id_i,
                        word_offset: req_word_offset_i, valid_words: req_valid_words_i};
    assign dma_in   = '{coh_msg: dma_coh_msg_i, hprot: dma_hprot_i, addr: dma_addr_i,
                        line: dma_line_i, req_id: dma_req_id_i,
                        word_offset: dma_word_offset_i, valid_words: dma_valid_words_i};

    llc_bypass_slot #(.payload_t(llc_flush_t)) u_flush_slot (
        .clk(clk), .rst(rst),
        .valid_i(flush_valid_i), .data_i(flush_in), .ready_o(flush_ready_o),
        .valid_o(flush_vld), .data_o(flush_out), .grant_i(flush_gnt)
    );

    llc_bypass_slot #(.payload_t(llc_mem_rsp_t)) u_mem_rsp_slot (
        .clk(clk), .rst(rst),
        .valid_i(mem_rsp_valid_i), .data_i(mem_in), .ready_o(mem_rsp_ready_o),
        .valid_o(mem_vld), .data_o(mem_out), .grant_i(mem_gnt)
    );

    llc_bypass_slot #(.payload_t(llc_rsp_t)) u_rsp_slot (
        .clk(clk), .rst(rst),
        .valid_i(rsp_valid_i), .data_i(rsp_in), .ready_o(rsp_ready_o),
        .valid_o(rsp_vld), .data_o(rsp_out), .grant_i(rsp_gnt)
    );

    llc_bypass_slot #(.payload_t(llc_req_t)) u_req_slot (
        .clk(clk), .rst(rst),
        .valid_i(req_valid_i), .data_i(req_in), .ready_o(req_ready_o),
        .valid_o(req_vld), .data_o(req_out), .grant_i(req_gnt)
    );

    llc_bypass_slot #(.payload_t(llc_req_t)) u_dma_slot (
        .clk(clk), .rst(rst),
        .valid_i(dma_valid_i), .data_i(dma_in), .ready_o(dma_ready_o),
        .valid_o(dma_vld), .data_o(dma_out), .grant_i(dma_gnt)
    );

    llc_input_cfg u_cfg (
        .clk(clk), .rst(rst),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o),
        .chan_en_o(chan_en), .dma_first_o(dma_first)
    );

    llc_channel_select u_select (
        .flush_valid_i(flush_vld), .flush_data_i(flush_out),
        .mem_valid_i(mem_vld), .mem_data_i(mem_out),
        .rsp_valid_i(rsp_vld), .rsp_data_i(rsp_out),
        .req_valid_i(req_vld), .req_data_i(req_out),
        .dma_valid_i(dma_vld), .dma_data_i(dma_out),
        .chan_en_i(chan_en), .dma_first_i(dma_first), .sel_ready_i(sel_ready_i),
        .flush_grant_o(flush_gnt), .mem_grant_o(mem_gnt), .rsp_grant_o(rsp_gnt),
        .req_grant_o(req_gnt), .dma_grant_o(dma_gnt),
        .sel_valid_o(sel_valid_o), .sel_chan_o(sel_chan_o),
        .sel_coh_msg_o(sel_coh_msg_o), .sel_hprot_o(sel_hprot_o),
        .sel_addr_o(sel_addr_o), .sel_line_o(sel_line_o),
        .sel_req_id_o(sel_req_id_o), .sel_word_offset_o(sel_word_offset_o),
        .sel_valid_words_o(sel_valid_words_o), .sel_flush_o(sel_flush_o)
    );

endmodule

`default_nettype wire

// File: test/llc_input_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module llc_input_stage_assertions
    import llc_msg_pkg::*;
    import llc_chan_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [CHAN_MASK_W-1:0] up_valid_i,
    input  logic [CHAN_MASK_W-1:0] up_ready_i,
    input  llc_flush_t             flush_in_i,
    input  llc_mem_rsp_t           mem_in_i,
    input  llc_rsp_t               rsp_in_i,
    input  llc_req_t               req_in_i,
    input  llc_req_t               dma_in_i,
    input  logic                   sel_ready_i,
    input  logic                   sel_valid_i,
    input  chan_id_t               sel_chan_i,
    // Unified fields other than flush share the request layout
    input  llc_req_t               sel_req_i,
    input  logic                   sel_flush_i,
    input  logic                   cfg_we_i,
    input  logic                   cfg_addr_i,
    input  logic [CHAN_MASK_W-1:0] cfg_wdata_i,
    input  logic [CHAN_MASK_W-1:0] cfg_rdata_i
);

    // Unified output fields, flush flag last
    typedef struct packed {
        llc_req_t req;
        logic     flush;
    } offer_t;

    int unsigned            fail_count = 0;
    logic [CHAN_MASK_W-1:0] pend;
    logic [CHAN_MASK_W-1:0] deliv;
    logic [CHAN_MASK_W-1:0] mask_exp;
    logic                   prio_exp;
    logic [CHAN_MASK_W-1:0] cfg_exp;
    chan_id_t               exp_chan;
    offer_t                 live [CHAN_MASK_W];
    offer_t                 park [CHAN_MASK_W];
    offer_t                 exp_offer;
    offer_t                 got_offer;
    int unsigned            acc_cnt [CHAN_MASK_W];
    int unsigned            del_cnt [CHAN_MASK_W];

    // Channel code c sits at mask bit c-1
    function automatic chan_id_t top_chan(input logic [CHAN_MASK_W-1:0] p, input logic dma_first);
        chan_id_t order [CHAN_MASK_W];
        chan_id_t best;
        order = '{CH_FLUSH, CH_MEM_RSP, CH_RSP, CH_REQ, CH_DMA};
        if (dma_first) begin
            order[3] = CH_DMA;
            order[4] = CH_REQ;
        end
        best = CH_NONE;
        // Walk from lowest priority so the highest pending one wins
        for (int k = CHAN_MASK_W - 1; k >= 0; k--) begin
            if (p[order[k] - 1]) begin
                best = order[k];
            end
        end
        return best;
    endfunction

    always_comb begin
        // A parked message exists exactly while ready is low
        pend     = ~up_ready_i | up_valid_i;
        exp_chan = top_chan(pend & mask_exp, prio_exp);
        cfg_exp  = (cfg_addr_i == CFG_ADDR_PRIO) ? CHAN_MASK_W'(prio_exp) : mask_exp;
        deliv    = '0;
        if (sel_valid_i && sel_ready_i && sel_chan_i != CH_NONE) begin
            deliv[sel_chan_i - 1] = 1'b1;
        end
        // Fields a channel does not carry read as zero
        for (int k = 0; k < CHAN_MASK_W; k++) begin
            live[k] = '0;
        end
        live[MASK_FLUSH].flush        = flush_in_i.flush;
        live[MASK_MEM_RSP].req.line   = mem_in_i.line;
        live[MASK_RSP].req.coh_msg    = rsp_in_i.coh_msg;
        live[MASK_RSP].req.addr       = rsp_in_i.addr;
        live[MASK_RSP].req.line       = rsp_in_i.line;
        live[MASK_RSP].req.req_id     = rsp_in_i.req_id;
        live[MASK_REQ].req            = req_in_i;
        live[MASK_DMA].req            = dma_in_i;
        got_offer = '{req: sel_req_i, flush: sel_flush_i};
        exp_offer = '0;
        for (int k = 0; k < CHAN_MASK_W; k++) begin
            if (deliv[k]) begin
                exp_offer = up_ready_i[k] ? live[k] : park[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mask_exp <= CFG_MASK_RST;
            prio_exp <= CFG_PRIO_RST;
            for (int k = 0; k < CHAN_MASK_W; k++) begin
                acc_cnt[k] <= 0;
                del_cnt[k] <= 0;
            end
        end else begin
            if (cfg_we_i && cfg_addr_i == CFG_ADDR_MASK) begin
                mask_exp <= cfg_wdata_i;
            end
            if (cfg_we_i && cfg_addr_i == CFG_ADDR_PRIO) begin
                prio_exp <= cfg_wdata_i[0];
            end
            for (int k = 0; k < CHAN_MASK_W; k++) begin
                if (up_valid_i[k] && up_ready_i[k]) begin
                    acc_cnt[k] <= acc_cnt[k] + 1;
                end
                if (deliv[k]) begin
                    del_cnt[k] <= del_cnt[k] + 1;
                end
            end
        end
    end

    // Copy of each parked message as the core should see it
    always_ff @(posedge clk) begin
        for (int k = 0; k < CHAN_MASK_W; k++) begin
            if (up_valid_i[k] && up_ready_i[k] && !deliv[k]) begin
                park[k] <= live[k];
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) $rose(rst) |-> (&up_ready_i) && !sel_valid_i)
        else begin
            fail_count++;
            $error("ready or sel_valid wrong right after reset");
        end

    a_select: assert property (@(posedge clk) disable iff (!rst)
        (sel_chan_i == exp_chan) && (sel_valid_i == (exp_chan != CH_NONE)))
        else begin
            fail_count++;
            $error("selected channel %0d, expected %0d", sel_chan_i, exp_chan);
        end

    a_cfg_read: assert property (@(posedge clk) disable iff (!rst)
        cfg_rdata_i == cfg_exp)
        else begin
            fail_count++;
            $error("config readback %b, expected %b", cfg_rdata_i, cfg_exp);
        end

    a_fields: assert property (@(posedge clk) disable iff (!rst)
        (deliv != '0) |-> (got_offer == exp_offer))
        else begin
            fail_count++;
            $error("delivered fields %h, expected %h", got_offer, exp_offer);
        end

    for (genvar i = 0; i < CHAN_MASK_W; i++) begin : g_chan
        a_capture: assert property (@(posedge clk) disable iff (!rst)
            up_valid_i[i] && up_ready_i[i] && !deliv[i] |=> !up_ready_i[i])
            else begin
                fail_count++;
                $error("channel bit %0d kept ready after parking a message", i);
            end

        a_release: assert property (@(posedge clk) disable iff (!rst)
            deliv[i] |=> up_ready_i[i])
            else begin
                fail_count++;
                $error("channel bit %0d not ready again after delivery", i);
            end

        // Accepted minus delivered is the number of parked messages
        a_count: assert property (@(posedge clk) disable iff (!rst)
            up_ready_i[i] ? (acc_cnt[i] == del_cnt[i]) : (acc_cnt[i] == del_cnt[i] + 1))
            else begin
                fail_count++;
                $error("channel bit %0d accepted %0d, delivered %0d", i, acc_cnt[i], del_cnt[i]);
            end
    end

endmodule

bind llc_input_stage llc_input_stage_assertions u_chk (
    .clk(clk),
    .rst(rst),
    .up_valid_i({dma_valid_i, req_valid_i, rsp_valid_i, mem_rsp_valid_i, flush_valid_i}),
    .up_ready_i({dma_ready_o, req_ready_o, rsp_ready_o, mem_rsp_ready_o, flush_ready_o}),
    .flush_in_i(flush_flag_i),
    .mem_in_i(mem_rsp_line_i),
    .rsp_in_i({rsp_coh_msg_i, rsp_addr_i, rsp_line_i, rsp_req_id_i}),
    .req_in_i({req_coh_msg_i, req_hprot_i, req_addr_i, req_line_i, req_req_id_i,
               req_word_offset_i, req_valid_words_i}),
    .dma_in_i({dma_coh_msg_i, dma_hprot_i, dma_addr_i, dma_line_i, dma_req_id_i,
               dma_word_offset_i, dma_valid_words_i}),
    .sel_ready_i(sel_ready_i),
    .sel_valid_i(sel_valid_o),
    .sel_chan_i(sel_chan_o),
    .sel_req_i({sel_coh_msg_o, sel_hprot_o, sel_addr_o, sel_line_o, sel_req_id_o,
                sel_word_offset_o, sel_valid_words_o}),
    .sel_flush_i(sel_flush_o),
    .cfg_we_i(cfg_we_i),
    .cfg_addr_i(cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .cfg_rdata_i(cfg_rdata_o)
);

`default_nettype wire

// File: test/llc_input_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module llc_input_stage_tb
    import llc_msg_pkg::*;
    import llc_chan_pkg::*;
();

    logic                   clk;
    logic                   rst;
    logic                   cfg_we_i;
    logic                   cfg_addr_i;
    logic [CHAN_MASK_W-1:0] cfg_wdata_i;
    logic [CHAN_MASK_W-1:0] cfg_rdata_o;
    logic                   flush_valid_i;
    logic                   flush_ready_o;
    logic                   flush_flag_i;
    logic                   mem_rsp_valid_i;
    logic                   mem_rsp_ready_o;
    logic [LINE_W-1:0]      mem_rsp_line_i;
    logic                   rsp_valid_i;
    logic                   rsp_ready_o;
    logic [COH_MSG_W-1:0]   rsp_coh_msg_i;
    logic [ADDR_W-1:0]      rsp_addr_i;
    logic [LINE_W-1:0]      rsp_line_i;
    logic [REQ_ID_W-1:0]    rsp_req_id_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    logic [COH_MSG_W-1:0]   req_coh_msg_i;
    logic [HPROT_W-1:0]     req_hprot_i;
    logic [ADDR_W-1:0]      req_addr_i;
    logic [LINE_W-1:0]      req_line_i;
    logic [REQ_ID_W-1:0]    req_req_id_i;
    logic [WORD_OFF_W-1:0]  req_word_offset_i;
    logic [WORD_OFF_W-1:0]  req_valid_words_i;
    logic                   dma_valid_i;
    logic                   dma_ready_o;
    logic [COH_MSG_W-1:0]   dma_coh_msg_i;
    logic [HPROT_W-1:0]     dma_hprot_i;
    logic [ADDR_W-1:0]      dma_addr_i;
    logic [LINE_W-1:0]      dma_line_i;
    logic [REQ_ID_W-1:0]    dma_req_id_i;
    logic [WORD_OFF_W-1:0]  dma_word_offset_i;
    logic [WORD_OFF_W-1:0]  dma_valid_words_i;
    logic                   sel_ready_i;
    logic                   sel_valid_o;
    chan_id_t               sel_chan_o;
    logic [COH_MSG_W-1:0]   sel_coh_msg_o;
    logic [HPROT_W-1:0]     sel_hprot_o;
    logic [ADDR_W-1:0]      sel_addr_o;
    logic [LINE_W-1:0]      sel_line_o;
    logic [REQ_ID_W-1:0]    sel_req_id_o;
    logic [WORD_OFF_W-1:0]  sel_word_offset_o;
    logic [WORD_OFF_W-1:0]  sel_valid_words_o;
    logic                   sel_flush_o;
    logic [CHAN_MASK_W-1:0] readies;
    int unsigned            pass_tests;
    int unsigned            fail_tests;
    int unsigned            fails_at_start;
    bit                     test_ok;

    llc_input_stage u_dut (.*);

    assign readies = {dma_ready_o, req_ready_o, rsp_ready_o, mem_rsp_ready_o, flush_ready_o};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [CHAN_MASK_W-1:0] chan_bit(input int idx);
        return CHAN_MASK_W'(1) << idx;
    endfunction

    task automatic randomize_fields();
        flush_flag_i      <= 1'($urandom);
        mem_rsp_line_i    <= {$urandom, $urandom};
        rsp_coh_msg_i     <= COH_MSG_W'($urandom);
        rsp_addr_i        <= ADDR_W'($urandom);
        rsp_line_i        <= {$urandom, $urandom};
        rsp_req_id_i      <= REQ_ID_W'($urandom);
        req_coh_msg_i     <= COH_MSG_W'($urandom);
        req_hprot_i       <= HPROT_W'($urandom);
        req_addr_i        <= ADDR_W'($urandom);
        req_line_i        <= {$urandom, $urandom};
        req_req_id_i      <= REQ_ID_W'($urandom);
        req_word_offset_i <= WORD_OFF_W'($urandom);
        req_valid_words_i <= WORD_OFF_W'($urandom);
        dma_coh_msg_i     <= COH_MSG_W'($urandom);
        dma_hprot_i       <= HPROT_W'($urandom);
        dma_addr_i        <= ADDR_W'($urandom);
        dma_line_i        <= {$urandom, $urandom};
        dma_req_id_i      <= REQ_ID_W'($urandom);
        dma_word_offset_i <= WORD_OFF_W'($urandom);
        dma_valid_words_i <= WORD_OFF_W'($urandom);
    endtask

    task automatic drive_valids(input logic [CHAN_MASK_W-1:0] v);
        flush_valid_i   <= v[MASK_FLUSH];
        mem_rsp_valid_i <= v[MASK_MEM_RSP];
        rsp_valid_i     <= v[MASK_RSP];
        req_valid_i     <= v[MASK_REQ];
        dma_valid_i     <= v[MASK_DMA];
    endtask

    // One cycle of traffic on the chosen channels
    task automatic pulse(input logic [CHAN_MASK_W-1:0] v);
        @(posedge clk);
        randomize_fields();
        drive_valids(v);
        @(posedge clk);
        drive_valids('0);
    endtask

    task automatic cfg_write(input logic addr, input logic [CHAN_MASK_W-1:0] data);
        @(posedge clk);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i <= 1'b0;
    endtask

    task automatic set_sel_ready(input logic value);
        @(posedge clk);
        sel_ready_i <= value;
    endtask

    task automatic wait_ready(input logic [CHAN_MASK_W-1:0] want, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (readies !== want && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (readies !== want) begin
            $display("timeout: %s, ready lines stayed at %b instead of %b", what, readies, want);
            test_ok = 1'b0;
        end
    endtask

    task automatic begin_test();
        fails_at_start = u_dut.u_chk.fail_count;
        test_ok        = 1'b1;
    endtask

    task automatic end_test(input string name);
        int unsigned seen;
        // Let checks that look one cycle ahead settle
        repeat (2) @(negedge clk);
        seen = u_dut.u_chk.fail_count - fails_at_start;
        if (seen != 0) begin
            $display("error: %s expected 0 assertion failures, actual %0d", name, seen);
            test_ok = 1'b0;
        end
        if (test_ok) begin
            pass_tests++;
            $display("test %s: pass", name);
        end else begin
            fail_tests++;
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        void'($urandom(32'h9234_f194));
        pass_tests  = 0;
        fail_tests  = 0;
        rst         = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = CFG_ADDR_MASK;
        cfg_wdata_i = '0;
        sel_ready_i = 1'b0;
        drive_valids('0);
        randomize_fields();
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        begin_test();
        set_sel_ready(1'b1);
        pulse(chan_bit(MASK_REQ));
        wait_ready('1, "bypassed request left the slot busy");
        end_test("reset_bypass");

        begin_test();
        set_sel_ready(1'b0);
        pulse(chan_bit(MASK_REQ));
        wait_ready(~chan_bit(MASK_REQ), "request not parked under stall");
        repeat (3) @(posedge clk);
        sel_ready_i <= 1'b1;
        wait_ready('1, "parked request never delivered");
        end_test("backpressure");

        begin_test();
        set_sel_ready(1'b0);
        pulse('1);
        wait_ready('0, "not all five slots filled");
        set_sel_ready(1'b1);
        wait_ready('1, "slots did not drain");
        end_test("priority_order");

        begin_test();
        cfg_write(CFG_ADDR_PRIO, CHAN_MASK_W'(1));
        set_sel_ready(1'b0);
        pulse(chan_bit(MASK_REQ) | chan_bit(MASK_DMA));
        wait_ready(~(chan_bit(MASK_REQ) | chan_bit(MASK_DMA)), "request slots not filled");
        set_sel_ready(1'b1);
        wait_ready('1, "request slots did not drain");
        cfg_write(CFG_ADDR_PRIO, '0);
        end_test("dma_first");

        begin_test();
        cfg_write(CFG_ADDR_MASK, ~chan_bit(MASK_REQ));
        set_sel_ready(1'b1);
        pulse(chan_bit(MASK_REQ));
        wait_ready(~chan_bit(MASK_REQ), "masked request was not parked");
        repeat (5) @(posedge clk);
        cfg_write(CFG_ADDR_MASK, '1);
        wait_ready('1, "re-enabled request never delivered");
        end_test("enable_mask");

        begin_test();
        repeat (500) begin
            @(posedge clk);
            sel_ready_i <= ($urandom % 4) != 0;
            randomize_fields();
            drive_valids(CHAN_MASK_W'($urandom));
        end
        @(posedge clk);
        drive_valids('0);
        sel_ready_i <= 1'b1;
        wait_ready('1, "random traffic did not drain");
        end_test("random_stall");

        $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/llc_msg_pkg.sv
hdl/llc_chan_pkg.sv
hdl/llc_bypass_slot.sv
hdl/llc_input_cfg.sv
hdl/llc_channel_select.sv
hdl/llc_input_stage.sv
test/llc_input_stage_assertions.sv
test/llc_input_stage_tb.sv
